// ==== tb.f ====
source/sens_io_pkg.sv
source/sens_cmd_deser.sv
source/sens_ctrl_regs.sv
source/sens_jtag_regs.sv
source/sens_pin_mux.sv
source/sens_ext_clk.sv
source/sens_io_top.sv
tests/sens_io_asserts.sv
tests/tb_sens_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sens_io regression with Verilator, result decided from sim.log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_sens_io -o sim_tb_sens_io

./obj_dir/sim_tb_sens_io +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation finished without errors"
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

// ==== tests/tb_sens_io.sv ====
// directed tests on default parameters, expected pins come from a register model kept in here
`timescale 1ns/100ps

module tb_sens_io import sens_io_pkg::*; ();

    localparam int          PXD_DIV  = 10;
    localparam logic [15:0] BASE     = 16'h330;
    localparam logic [15:0] MASK     = 16'h7f8;
    localparam int          N_CTRL   = 12;  // random control writes
    localparam int          N_JTAG   = 6;
    localparam int          N_STAT   = 8;
    localparam int          SETTLE   = 4;   // probe pipeline after pgmen drops
    localparam int          CYCLES   = 4 + 3 * PXD_DIV + (N_CTRL + 7) * 10 + 40 + N_JTAG * 10
                                       + 4 * (10 + SETTLE) + N_STAT * 3;
    localparam int          WDOG_NS  = 8 * (CYCLES + 100); // test length plus margin

    logic           mclk, rst, cmd_stb, trigger_mode, trig, pgm_in, tdo_in, done_in;
    logic [7:0]     cmd_ad;
    logic           sns_mrst, sns_ctl_tck, sns_arst_tms, sns_gp0_tdi, sns_gp1;
    logic           sns_pgm, sns_pgm_oe, prsts, ext_clk;
    sens_pin_stat_t status;
    logic [31:0]    lfsr;
    logic m_mrst_n, m_arst, m_aro, m_pll, m_gp0, m_gp1;      // ctrl model
    logic m_pgmen, m_prog, m_tck, m_tms, m_tdi, m_force;     // jtag model

    sens_io_top #(.SENSIO_ADDR(BASE), .SENSIO_ADDR_MASK(MASK), .PXD_CLK_DIV(PXD_DIV)) i_dut (
        .mclk(mclk), .async_prst_with_sens_mrst_i(rst), .cmd_ad_i(cmd_ad), .cmd_stb_i(cmd_stb),
        .trigger_mode_i(trigger_mode), .trig_i(trig), .sns_mrst_o(sns_mrst),
        .sns_ctl_tck_o(sns_ctl_tck), .sns_arst_tms_o(sns_arst_tms), .sns_gp0_tdi_o(sns_gp0_tdi),
        .sns_gp1_o(sns_gp1), .sns_pgm_o(sns_pgm), .sns_pgm_oe_o(sns_pgm_oe), .sns_pgm_i(pgm_in),
        .sns_flash_tdo_i(tdo_in), .sns_shutter_done_i(done_in), .status_o(status),
        .prsts_o(prsts), .ext_clk_o(ext_clk)
    );

    always #4 mclk = ~mclk; // 8 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);       // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic field_next(input logic cur, input logic [31:0] w, input int pos);
        return w[pos + 1] ? w[pos] : cur; // enable sits one bit above value
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_stat(input string name, input sens_pin_stat_t exp,
                              input sens_pin_stat_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic apply_write(input logic [15:0] addr, input logic [31:0] w);
        if ((addr & MASK) == (BASE & MASK) && addr[2:0] == SENSIO_CTRL) begin
            m_mrst_n = field_next(m_mrst_n, w, SENS_CTRL_MRST);
            m_arst   = field_next(m_arst, w, SENS_CTRL_ARST);
            m_aro    = field_next(m_aro, w, SENS_CTRL_ARO);
            m_pll    = field_next(m_pll, w, SENS_CTRL_PLL_RST);
            m_gp0    = field_next(m_gp0, w, SENS_CTRL_GP0);
            m_gp1    = field_next(m_gp1, w, SENS_CTRL_GP1);
        end else if ((addr & MASK) == (BASE & MASK) && addr[2:0] == SENSIO_JTAG) begin
            m_pgmen  = field_next(m_pgmen, w, SENS_JTAG_PGMEN);
            m_prog   = field_next(m_prog, w, SENS_JTAG_PROG);
            m_tck    = field_next(m_tck, w, SENS_JTAG_TCK);
            m_tms    = field_next(m_tms, w, SENS_JTAG_TMS);
            m_tdi    = field_next(m_tdi, w, SENS_JTAG_TDI);
        end
    endtask

    task automatic check_pins(input string tname);
        logic aro_src;
        aro_src = trigger_mode ? !trig : m_aro;
        check_bit({tname, " sns_mrst_o"}, m_mrst_n, sns_mrst);
        check_bit({tname, " sns_ctl_tck_o"}, m_pgmen ? m_tck : aro_src, sns_ctl_tck);
        check_bit({tname, " sns_arst_tms_o"}, m_pgmen ? m_tms : m_arst, sns_arst_tms);
        check_bit({tname, " sns_gp0_tdi_o"}, m_pgmen ? m_tdi : m_gp0, sns_gp0_tdi);
        check_bit({tname, " sns_gp1_o"}, m_gp1, sns_gp1);
        check_bit({tname, " sns_pgm_o"}, m_pgmen ? !m_prog : m_force, sns_pgm); // PROG_B
        check_bit({tname, " sns_pgm_oe_o"}, m_pgmen || m_force, sns_pgm_oe);
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] w);
        logic [47:0] bytes;
        bytes = {w, addr}; // AL first on the wire
        for (int i = 0; i < 6; i++) begin
            @(negedge mclk);
            cmd_stb = (i == 0);
            cmd_ad  = bytes[8*i +: 8];
        end
        @(negedge mclk); // D3 sampled on the edge before
        cmd_ad = 8'h00;
    endtask

    task automatic write_and_check(input string tname, input logic [15:0] addr,
                                   input logic [31:0] w);
        send_cmd(addr, w);
        repeat (2) @(negedge mclk);      // we pulse, register update
        check_pins({tname, " before"});  // pins still old
        apply_write(addr, w);
        @(negedge mclk);                 // third edge, pin flops
        check_pins(tname);
    endtask

    task automatic reset_state();
        int   waited;
        logic level;
        check_pins("reset_state");
        check_stat("reset_state status_o", '0, status);
        check_bit("reset_state prsts_o", 1'b1, prsts);
        check_bit("reset_state ext_clk_o", 1'b0, ext_clk);
        waited = 0;
        level  = ext_clk;
        while (ext_clk == level) begin   // wait for first toggle
            @(negedge mclk);
            waited++;
            if (waited > PXD_DIV) abort_run("ext_clk_o never toggled after reset");
        end
        level = ext_clk;
        for (int k = 1; k <= PXD_DIV / 2; k++) begin
            @(negedge mclk);
            check_bit("reset_state ext_clk_o", (k == PXD_DIV / 2) ? !level : level, ext_clk);
        end
    endtask

    task automatic ctrl_fields();
        for (int i = 0; i < N_CTRL; i++) begin
            write_and_check("ctrl_fields", {BASE[15:3], SENSIO_CTRL}, rand_bits(32));
        end
        write_and_check("ctrl_fields zero", {BASE[15:3], SENSIO_CTRL}, 32'h0000_a0aa); // all low
        write_and_check("ctrl_fields miss", BASE ^ 16'h0040, 32'hffff_ffff); // outside mask
        write_and_check("ctrl_fields rel", {BASE[15:3], SENSIO_CTRL}, 32'h0000_0083);
        check_bit("ctrl_fields prsts_o hold", 1'b1, prsts);    // one edge after register
        @(negedge mclk);
        check_bit("ctrl_fields prsts_o clear", 1'b0, prsts);   // two edges after
        write_and_check("ctrl_fields pll", {BASE[15:3], SENSIO_CTRL}, 32'h0000_00c0);
        check_bit("ctrl_fields prsts_o pll set", 1'b1, prsts); // PLL reset alone
        write_and_check("ctrl_fields pll off", {BASE[15:3], SENSIO_CTRL}, 32'h0000_0080);
        check_bit("ctrl_fields prsts_o pll hold", 1'b1, prsts);
        @(negedge mclk);
        check_bit("ctrl_fields prsts_o pll clear", 1'b0, prsts);
    endtask

    task automatic aro_trigger();
        logic [31:0] r;
        write_and_check("aro_trigger soft on", {BASE[15:3], SENSIO_CTRL}, 32'h0000_0030);
        write_and_check("aro_trigger soft off", {BASE[15:3], SENSIO_CTRL}, 32'h0000_0020);
        @(negedge mclk);
        trigger_mode = 1'b1;
        for (int i = 0; i < 16; i++) begin
            r    = rand_bits(1);
            trig = r[0];
            @(negedge mclk);
            check_bit("aro_trigger sns_ctl_tck_o", !trig, sns_ctl_tck); // one edge later
        end
        trigger_mode = 1'b0;
        @(negedge mclk);
        check_pins("aro_trigger back");
    endtask

    task automatic jtag_mode();
        for (int i = 0; i < N_JTAG; i++) begin
            write_and_check("jtag_mode", {BASE[15:3], SENSIO_JTAG}, rand_bits(32) | 32'h300);
            check_bit("jtag_mode sns_pgm_oe_o", 1'b1, sns_pgm_oe);
        end
    endtask

    task automatic pgm_probe();
        logic [31:0]    r;
        sens_pin_stat_t pins, prev;
        for (int lvl = 1; lvl >= 0; lvl--) begin
            @(negedge mclk);
            pgm_in = lvl[0];                                               // pin level to probe
            write_and_check("pgm_probe enter", {BASE[15:3], SENSIO_JTAG}, 32'h0000_0300);
            write_and_check("pgm_probe leave", {BASE[15:3], SENSIO_JTAG}, 32'h0000_0200);
            m_force = lvl[0];
            repeat (SETTLE) @(negedge mclk);
            check_pins("pgm_probe");
        end
        prev = '{done: done_in, tdo: tdo_in, pgm: pgm_in}; // levels held long enough
        for (int i = 0; i < N_STAT; i++) begin
            r    = rand_bits(3);
            pins = r[2:0];
            @(negedge mclk);
            done_in = pins.done;
            tdo_in  = pins.tdo;
            pgm_in  = pins.pgm;
            @(negedge mclk);
            check_stat("pgm_probe status_o early", prev, status);
            @(negedge mclk);
            check_stat("pgm_probe status_o", pins, status); // two edges after drive
            prev = pins;
        end
    endtask

    initial begin
        #(WDOG_NS);
        abort_run("timeout, tests did not complete within the watchdog time");
    end

    initial begin
        mclk = 1'b0;
        rst  = 1'b1;
        {cmd_stb, trigger_mode, trig, pgm_in, tdo_in, done_in} = '0;
        cmd_ad = 8'h00;
        lfsr   = 32'hb17c2146;
        {m_mrst_n, m_arst, m_aro, m_pll, m_gp0, m_gp1} = '0;    // reset values
        {m_pgmen, m_prog, m_tck, m_tms, m_tdi, m_force} = '0;
        repeat (2) @(negedge mclk);
        rst = 1'b0;
        reset_state();
        ctrl_fields();
        aro_trigger();
        jtag_mode();
        pgm_probe();
        if (i_dut.i_pin_mux.i_asserts.fail_cnt != 0) begin
            $display("concurrent assertion failures: %0d", i_dut.i_pin_mux.i_asserts.fail_cnt);
            $display("Regression failed");
            $fatal(1);
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== tests/sens_io_asserts.sv ====
// bound into sens_pin_mux, checks are off while reset is high and count their own failures
`timescale 1ns/100ps

module sens_io_asserts (
    input logic mclk,
    input logic async_prst_with_sens_mrst_i,
    input logic pgmen_i,
    input logic pgm_force_i,
    input logic trig_mode_i, // triggered ARO select
    input logic trig_i,      // trigger pin
    input logic aro_soft_i,  // ARO register bit
    input logic ctl_tck_i,   // registered TCK/ARO pin
    input logic pgm_oe_i     // registered PGM output enable
);

    int fail_cnt; // polled by the testbench at the end
    initial fail_cnt = 0;

    // enable only from program mode or the probe
    oe_source: assert property (@(posedge mclk) disable iff (async_prst_with_sens_mrst_i)
        pgm_oe_i |-> $past(pgmen_i || pgm_force_i))
        else begin
            fail_cnt++;
            $error("PGM output enable high without pgmen or forced level");
        end

    // outside program mode the pin is inverted trig or the soft bit, one flop later
    aro_to_tck: assert property (@(posedge mclk) disable iff (async_prst_with_sens_mrst_i)
        !$past(pgmen_i) |-> (ctl_tck_i == $past(trig_mode_i ? !trig_i : aro_soft_i)))
        else begin
            fail_cnt++;
            $error("TCK pin does not follow the ARO source");
        end

endmodule

bind sens_pin_mux sens_io_asserts i_asserts (
    .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
    .pgmen_i(pgmen_i), .pgm_force_i(pgm_force_i), .trig_mode_i(trigger_mode_i),
    .trig_i(trig_i), .aro_soft_i(aro_soft_i),
    .ctl_tck_i(sns_ctl_tck_o), .pgm_oe_i(sns_pgm_oe_o)
);

// ==== source/sens_io_top.sv ====
// sensor slow control on mclk only, bidirectional PGM pad is built outside from i/o/oe
`timescale 1ns/100ps

module sens_io_top import sens_io_pkg::*; #(
    parameter int unsigned SENSIO_ADDR      = 'h330,
    parameter int unsigned SENSIO_ADDR_MASK = 'h7f8,
    parameter int          PXD_CLK_DIV      = 10     // even
) (
    input  logic           mclk,
    input  logic           async_prst_with_sens_mrst_i,
    input  logic [7:0]     cmd_ad_i,
    input  logic           cmd_stb_i,
    input  logic           trigger_mode_i,
    input  logic           trig_i,
    output logic           sns_mrst_o,
    output logic           sns_ctl_tck_o,
    output logic           sns_arst_tms_o,
    output logic           sns_gp0_tdi_o,
    output logic           sns_gp1_o,
    output logic           sns_pgm_o,
    output logic           sns_pgm_oe_o,
    input  logic           sns_pgm_i,
    input  logic           sns_flash_tdo_i,
    input  logic           sns_shutter_done_i,
    output sens_pin_stat_t status_o,
    output logic           prsts_o,
    output logic           ext_clk_o
);

    logic           cmd_we;
    logic [2:0]     cmd_addr;
    sens_cmd_word_u cmd_data;
    logic           sens_mrst_n, sens_arst, aro_soft, gp0, gp1;
    logic           pgmen, prog, tck, tms, tdi, pgm_force, pgm_sync;

    sens_cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) i_cmd_deser (
        .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
        .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .cmd_we_o(cmd_we), .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data)
    );

    sens_ctrl_regs i_ctrl_regs (
        .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
        .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
        .sens_mrst_n_o(sens_mrst_n), .sens_arst_o(sens_arst), .aro_soft_o(aro_soft),
        .gp0_o(gp0), .gp1_o(gp1), .prsts_o(prsts_o)
    );

    sens_jtag_regs i_jtag_regs (
        .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
        .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
        .pgm_sync_i(pgm_sync), .pgmen_o(pgmen), .prog_o(prog), .tck_o(tck),
        .tms_o(tms), .tdi_o(tdi), .pgm_force_o(pgm_force)
    );

    sens_pin_mux i_pin_mux (
        .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
        .trigger_mode_i(trigger_mode_i), .trig_i(trig_i),
        .sens_mrst_n_i(sens_mrst_n), .sens_arst_i(sens_arst), .aro_soft_i(aro_soft),
        .gp0_i(gp0), .gp1_i(gp1), .pgmen_i(pgmen), .prog_i(prog), .tck_i(tck),
        .tms_i(tms), .tdi_i(tdi), .pgm_force_i(pgm_force),
        .sns_mrst_o(sns_mrst_o), .sns_ctl_tck_o(sns_ctl_tck_o),
        .sns_arst_tms_o(sns_arst_tms_o), .sns_gp0_tdi_o(sns_gp0_tdi_o),
        .sns_gp1_o(sns_gp1_o), .sns_pgm_o(sns_pgm_o), .sns_pgm_oe_o(sns_pgm_oe_o),
        .sns_pgm_i(sns_pgm_i), .sns_flash_tdo_i(sns_flash_tdo_i),
        .sns_shutter_done_i(sns_shutter_done_i),
        .pgm_sync_o(pgm_sync), .status_o(status_o)
    );

    sens_ext_clk #(
        .PXD_CLK_DIV (PXD_CLK_DIV)
    ) i_ext_clk (
        .mclk(mclk), .async_prst_with_sens_mrst_i(async_prst_with_sens_mrst_i),
        .ext_clk_o(ext_clk_o)
    );

endmodule

// ==== source/sens_ext_clk.sv ====
// reference clock for the sensor PLL, PXD_CLK_DIV must be even and at least 2
`timescale 1ns/100ps

module sens_ext_clk #(
    parameter int PXD_CLK_DIV = 10 // mclk cycles per output period
) (
    input  logic mclk,
    input  logic async_prst_with_sens_mrst_i,
    output logic ext_clk_o
);

    localparam int HALF  = PXD_CLK_DIV / 2;
    localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CNT_W-1:0] half_cnt; // counts down one half period

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            half_cnt  <= CNT_W'(HALF - 1);
            ext_clk_o <= 1'b0;
        end else if (half_cnt == '0) begin
            half_cnt  <= CNT_W'(HALF - 1); // reload
            ext_clk_o <= !ext_clk_o;       // 50 percent duty
        end else begin
            half_cnt  <= half_cnt - 1'b1;
        end
    end

endmodule

// ==== source/sens_pin_mux.sv ====
// all sensor pin outputs registered, inputs through 2-flop synchronizers, PGM split into i/o/oe
`timescale 1ns/100ps

module sens_pin_mux import sens_io_pkg::*; (
    input  logic           mclk,
    input  logic           async_prst_with_sens_mrst_i,
    input  logic           trigger_mode_i,  // 1 = triggered, 0 = free running
    input  logic           trig_i,          // per-sensor trigger
    input  logic           sens_mrst_n_i,
    input  logic           sens_arst_i,
    input  logic           aro_soft_i,
    input  logic           gp0_i,
    input  logic           gp1_i,
    input  logic           pgmen_i,
    input  logic           prog_i,
    input  logic           tck_i,
    input  logic           tms_i,
    input  logic           tdi_i,
    input  logic           pgm_force_i,
    output logic           sns_mrst_o,
    output logic           sns_ctl_tck_o,   // ARO or TCK
    output logic           sns_arst_tms_o,  // ARST or TMS
    output logic           sns_gp0_tdi_o,   // GP0 or TDI
    output logic           sns_gp1_o,
    output logic           sns_pgm_o,
    output logic           sns_pgm_oe_o,
    input  logic           sns_pgm_i,
    input  logic           sns_flash_tdo_i,
    input  logic           sns_shutter_done_i,
    output logic           pgm_sync_o,      // to the probe
    output sens_pin_stat_t status_o
);

    logic           aro;       // ARO source before the pin flop
    sens_pin_stat_t pin_meta;  // first synchronizer stage

    assign aro        = trigger_mode_i ? !trig_i : aro_soft_i;
    assign pgm_sync_o = status_o.pgm;

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            sns_mrst_o     <= 1'b0;
            sns_ctl_tck_o  <= 1'b0;
            sns_arst_tms_o <= 1'b0;
            sns_gp0_tdi_o  <= 1'b0;
            sns_gp1_o      <= 1'b0;
            sns_pgm_o      <= 1'b0;
            sns_pgm_oe_o   <= 1'b0; // pin released
        end else begin
            sns_mrst_o     <= sens_mrst_n_i;
            sns_ctl_tck_o  <= pgmen_i ? tck_i : aro;
            sns_arst_tms_o <= pgmen_i ? tms_i : sens_arst_i;
            sns_gp0_tdi_o  <= pgmen_i ? tdi_i : gp0_i;
            sns_gp1_o      <= gp1_i;
            sns_pgm_o      <= pgmen_i ? !prog_i : pgm_force_i; // PROG_B is inverted
            sns_pgm_oe_o   <= pgmen_i || pgm_force_i;
        end
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            pin_meta <= '0;
            status_o <= '0;
        end else begin
            pin_meta <= '{done: sns_shutter_done_i, tdo: sns_flash_tdo_i, pgm: sns_pgm_i};
            status_o <= pin_meta; // second stage
        end
    end

endmodule

// ==== source/sens_jtag_regs.sv ====
// external FPGA bit-bang register, PGM probe samples the synchronized pin when pgmen drops
`timescale 1ns/100ps

module sens_jtag_regs import sens_io_pkg::*; (
    input  logic           mclk,
    input  logic           async_prst_with_sens_mrst_i,
    input  logic           cmd_we_i,
    input  logic [2:0]     cmd_addr_i,
    input  sens_cmd_word_u cmd_data_i,
    input  logic           pgm_sync_i,  // PGM pin, already synchronized
    output logic           pgmen_o,     // program mode
    output logic           prog_o,      // PROG_B to external FPGA
    output logic           tck_o,
    output logic           tms_o,
    output logic           tdi_o,
    output logic           pgm_force_o  // probed PGM level
);

    sens_jtag_word_t wd;
    logic            set_jtag;
    logic [1:0]      pgmen_d;  // two samples of pgmen

    assign wd       = cmd_data_i.jtag;                            // jtag view of the word
    assign set_jtag = cmd_we_i && (cmd_addr_i == SENSIO_JTAG);

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            pgmen_o <= 1'b0;
            prog_o  <= 1'b0;
            tck_o   <= 1'b0;
            tms_o   <= 1'b0;
            tdi_o   <= 1'b0;
        end else if (set_jtag) begin
            if (wd.pgmen.en) pgmen_o <= wd.pgmen.val;
            if (wd.prog.en)  prog_o  <= wd.prog.val;
            if (wd.tck.en)   tck_o   <= wd.tck.val;
            if (wd.tms.en)   tms_o   <= wd.tms.val;
            if (wd.tdi.en)   tdi_o   <= wd.tdi.val;
        end
    end

    // probe, pin state right after leaving program mode is kept driven
    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            pgmen_d     <= 2'b00;
            pgm_force_o <= 1'b0;
        end else begin
            pgmen_d <= {pgmen_d[0], pgmen_o};
            if (pgmen_d == 2'b10) pgm_force_o <= pgm_sync_i; // falling edge of delayed pgmen
        end
    end

endmodule

// ==== source/sens_ctrl_regs.sv ====
// sensor control fields, each written only under its enable bit, prsts_o stretched by 2 mclk
`timescale 1ns/100ps

module sens_ctrl_regs import sens_io_pkg::*; (
    input  logic           mclk,
    input  logic           async_prst_with_sens_mrst_i,
    input  logic           cmd_we_i,
    input  logic [2:0]     cmd_addr_i,
    input  sens_cmd_word_u cmd_data_i,
    output logic           sens_mrst_n_o, // sensor master reset, active low
    output logic           sens_arst_o,   // analog reset
    output logic           aro_soft_o,    // software ARO level
    output logic           gp0_o,
    output logic           gp1_o,
    output logic           prsts_o        // sensor side reset, stretched
);

    sens_ctrl_word_t wd;
    logic            set_ctrl;
    logic            pll_rst;   // sensor PLL reset, internal only
    logic            rst_cause; // either reset active
    logic [1:0]      stretch;

    assign wd        = cmd_data_i.ctrl;                            // ctrl view of the word
    assign set_ctrl  = cmd_we_i && (cmd_addr_i == SENSIO_CTRL);
    assign rst_cause = !sens_mrst_n_o || pll_rst;
    assign prsts_o   = stretch[0];

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            sens_mrst_n_o <= 1'b0; // sensor held in reset
            sens_arst_o   <= 1'b0;
            aro_soft_o    <= 1'b0;
            pll_rst       <= 1'b0;
            gp0_o         <= 1'b0;
            gp1_o         <= 1'b0;
        end else if (set_ctrl) begin
            if (wd.mrst.en)    sens_mrst_n_o <= wd.mrst.val;
            if (wd.arst.en)    sens_arst_o   <= wd.arst.val;
            if (wd.aro.en)     aro_soft_o    <= wd.aro.val;    // own enable bit
            if (wd.pll_rst.en) pll_rst       <= wd.pll_rst.val;
            if (wd.gp0.en)     gp0_o         <= wd.gp0.val;
            if (wd.gp1.en)     gp1_o         <= wd.gp1.val;
        end
    end

    // reload on cause, then drain one bit per clock
    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            stretch <= 2'b11;
        end else if (rst_cause) begin
            stretch <= 2'b11;
        end else begin
            stretch <= stretch >> 1; // low 2 edges after cause clears
        end
    end

endmodule

// ==== source/sens_cmd_deser.sv ====
// six-byte command (AL AH D0 D1 D2 D3), no back-pressure, new strobe restarts a command
`timescale 1ns/100ps

module sens_cmd_deser import sens_io_pkg::*; #(
    parameter int unsigned SENSIO_ADDR      = 'h330, // base address
    parameter int unsigned SENSIO_ADDR_MASK = 'h7f8  // bits compared
) (
    input  logic           mclk,
    input  logic           async_prst_with_sens_mrst_i,
    input  logic [7:0]     cmd_ad_i,    // byte-serial address/data
    input  logic           cmd_stb_i,   // with first byte
    output logic           cmd_we_o,    // one-cycle write pulse
    output logic [2:0]     cmd_addr_o,  // local register address
    output sens_cmd_word_u cmd_data_o   // payload, both views
);

    localparam logic [15:0] ADDR_MASK  = 16'(SENSIO_ADDR_MASK);
    localparam logic [15:0] ADDR_MATCH = 16'(SENSIO_ADDR & SENSIO_ADDR_MASK);

    logic [47:0] sr;        // bytes enter at the top, AL ends up lowest
    logic [2:0]  byte_cnt;  // bytes taken so far
    logic        busy;      // inside a command
    logic        last;      // sixth byte just sampled
    logic        addr_hit;

    assign addr_hit = (sr[15:0] & ADDR_MASK) == ADDR_MATCH; // masked compare

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst_i) begin
        if (async_prst_with_sens_mrst_i) begin
            sr         <= '0;
            byte_cnt   <= '0;
            busy       <= 1'b0;
            last       <= 1'b0;
            cmd_we_o   <= 1'b0;
            cmd_addr_o <= '0;
            cmd_data_o <= '0;
        end else begin
            if (cmd_stb_i || busy) sr <= {cmd_ad_i, sr[47:8]}; // shift in
            if (cmd_stb_i) begin
                busy     <= 1'b1;   // restart on any strobe
                byte_cnt <= 3'd1;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 3'd1;
                if (byte_cnt == 3'd5) busy <= 1'b0; // sixth byte now
            end
            last     <= busy && !cmd_stb_i && (byte_cnt == 3'd5);
            cmd_we_o <= last && addr_hit; // only our address block
            if (last) begin
                cmd_addr_o <= sr[2:0];   // local address
                cmd_data_o <= sr[47:16]; // held past a back-to-back strobe
            end
        end
    end

endmodule

// ==== source/sens_io_pkg.sv ====
// shared encodings for the sensor slow-control port, field layouts assume 32-bit command data

package sens_io_pkg;

    // local register addresses, low 3 bits of the command address
    localparam logic [2:0] SENSIO_CTRL = 3'h0; // sensor control register
    localparam logic [2:0] SENSIO_JTAG = 3'h2; // external FPGA bit-bang register

    // control word, value bit of each field, enable is one bit up
    localparam int SENS_CTRL_MRST    = 0;  // sensor master reset, active low
    localparam int SENS_CTRL_ARST    = 2;  // analog reset
    localparam int SENS_CTRL_ARO     = 4;  // ARO soft level
    localparam int SENS_CTRL_PLL_RST = 6;  // sensor PLL reset
    localparam int SENS_CTRL_GP0     = 12; // general purpose 0
    localparam int SENS_CTRL_GP1     = 14; // general purpose 1

    // JTAG word, same value/enable pairing
    localparam int SENS_JTAG_TDI   = 0;
    localparam int SENS_JTAG_TMS   = 2;
    localparam int SENS_JTAG_TCK   = 4;
    localparam int SENS_JTAG_PROG  = 6;
    localparam int SENS_JTAG_PGMEN = 8; // program mode enable

    typedef struct packed {
        logic en;  // write enable for this field
        logic val; // new value
    } sens_field_t;

    typedef struct packed {
        logic [31-SENS_CTRL_GP1-2:0]              rsvd_hi;  // unused upper half
        sens_field_t                              gp1;      // 15:14
        sens_field_t                              gp0;      // 13:12
        logic [SENS_CTRL_GP0-SENS_CTRL_PLL_RST-3:0] rsvd_mid; // reserved, 11:8
        sens_field_t                              pll_rst;  // 7:6
        sens_field_t                              aro;      // 5:4
        sens_field_t                              arst;     // 3:2
        sens_field_t                              mrst;     // 1:0
    } sens_ctrl_word_t;

    typedef struct packed {
        logic [31-SENS_JTAG_PGMEN-2:0] rsvd; // unused
        sens_field_t                   pgmen; // 9:8
        sens_field_t                   prog;  // 7:6
        sens_field_t                   tck;   // 5:4
        sens_field_t                   tms;   // 3:2
        sens_field_t                   tdi;   // 1:0
    } sens_jtag_word_t;

    // one data word, read as ctrl or jtag depending on target register
    typedef union packed {
        sens_ctrl_word_t ctrl;
        sens_jtag_word_t jtag;
    } sens_cmd_word_u;

    typedef struct packed {
        logic done; // external FPGA DONE / shutter pin
        logic tdo;  // external FPGA TDO / flash pin
        logic pgm;  // PGM pin level
    } sens_pin_stat_t;

endpackage
